/* src/ReconPkg.sv */
// Constants for 4x4 luma blocks only; there is no chroma, no 16x16 DC (WHT) path and no entropy stage
`default_nettype none

package ReconPkg;

    // --------------------------------------------------
    // Block geometry and bus widths
    // --------------------------------------------------
    localparam int BlockSize = 4;
    localparam int NumCoeffs = BlockSize * BlockSize;
    localparam int PixW      = 8;
    localparam int CoeffW    = 12;
    localparam int LevelW    = 16;
    // q, iq and sharpen table entries
    localparam int QW        = 16;
    localparam int BiasW     = 32;
    // Sharpened magnitude times iq plus bias
    localparam int AccW      = 34;

    // --------------------------------------------------
    // Quantizer
    // --------------------------------------------------
    localparam int MaxLevel = 2047;
    localparam int QFix     = 17;

    // Raster position of each level in output order
    localparam int Zigzag [NumCoeffs] = '{
        0, 1, 4, 8, 5, 2, 3, 6, 9, 12, 13, 10, 7, 11, 14, 15
    };

    // --------------------------------------------------
    // Transform constants
    // --------------------------------------------------
    localparam int FtMulA = 2217;
    localparam int FtMulB = 5352;
    localparam int FtRndA = 1812;
    localparam int FtRndB = 937;
    localparam int FtRndC = 12000;
    localparam int FtRndD = 51000;

    // Inverse multipliers in Q16
    localparam int ItMulA = 20091;
    localparam int ItMulB = 35468;

    // Stage latencies in cycles
    localparam int FtLatency = 2;
    localparam int QbLatency = 2;
    localparam int ItLatency = 3;

endpackage

`default_nettype wire

/* src/FTransform.sv */
// Forward 4x4 DCT with no back-pressure; out is only valid in the cycle where done is high
`timescale 1ns/100ps
`default_nettype none

module FTransform (
    input  wire                                                   clk,
    input  wire                                                   rst_n,
    input  wire                                                   start,
    input  wire  [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]         src,
    input  wire  [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]         refPix,
    output logic [ReconPkg::CoeffW*ReconPkg::NumCoeffs-1:0]       out,
    output logic                                                  done
);

    int   rowNext [ReconPkg::NumCoeffs];
    int   rowReg  [ReconPkg::NumCoeffs];
    logic [ReconPkg::CoeffW*ReconPkg::NumCoeffs-1:0] colNext;
    logic startQ;

    // --------------------------------------------------
    // Residual and row pass
    // --------------------------------------------------
    always_comb begin
        int d [ReconPkg::BlockSize];
        int a0, a1, a2, a3;
        for (int i = 0; i < ReconPkg::BlockSize; i++) begin
            for (int k = 0; k < ReconPkg::BlockSize; k++) begin
                d[k] = int'(src[(i*4+k)*ReconPkg::PixW +: ReconPkg::PixW])
                     - int'(refPix[(i*4+k)*ReconPkg::PixW +: ReconPkg::PixW]);
            end
            a0 = d[0] + d[3];
            a1 = d[1] + d[2];
            a2 = d[1] - d[2];
            a3 = d[0] - d[3];
            rowNext[i*4+0] = (a0 + a1) * 8;
            rowNext[i*4+1] = (a2 * ReconPkg::FtMulA + a3 * ReconPkg::FtMulB
                              + ReconPkg::FtRndA) >>> 9;
            rowNext[i*4+2] = (a0 - a1) * 8;
            rowNext[i*4+3] = (a3 * ReconPkg::FtMulA - a2 * ReconPkg::FtMulB
                              + ReconPkg::FtRndB) >>> 9;
        end
    end

    // --------------------------------------------------
    // Column pass
    // --------------------------------------------------
    always_comb begin
        int a0, a1, a2, a3;
        int c0, c1, c2, c3;
        for (int i = 0; i < ReconPkg::BlockSize; i++) begin
            a0 = rowReg[i] + rowReg[12+i];
            a1 = rowReg[4+i] + rowReg[8+i];
            a2 = rowReg[4+i] - rowReg[8+i];
            a3 = rowReg[i] - rowReg[12+i];
            c0 = (a0 + a1 + 7) >>> 4;
            // Second AC term gets +1 whenever a3 is nonzero
            c1 = ((a2 * ReconPkg::FtMulA + a3 * ReconPkg::FtMulB
                   + ReconPkg::FtRndC) >>> 16) + int'(a3 != 0);
            c2 = (a0 - a1 + 7) >>> 4;
            c3 = (a3 * ReconPkg::FtMulA - a2 * ReconPkg::FtMulB
                  + ReconPkg::FtRndD) >>> 16;
            colNext[(i)*ReconPkg::CoeffW    +: ReconPkg::CoeffW] = c0[ReconPkg::CoeffW-1:0];
            colNext[(4+i)*ReconPkg::CoeffW  +: ReconPkg::CoeffW] = c1[ReconPkg::CoeffW-1:0];
            colNext[(8+i)*ReconPkg::CoeffW  +: ReconPkg::CoeffW] = c2[ReconPkg::CoeffW-1:0];
            colNext[(12+i)*ReconPkg::CoeffW +: ReconPkg::CoeffW] = c3[ReconPkg::CoeffW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rowReg <= '{default: 0};
            out    <= '0;
            startQ <= 1'b0;
            done   <= 1'b0;
        end else begin
            rowReg <= rowNext;
            out    <= colNext;
            startQ <= start;
            done   <= startQ;
        end
    end

    // Every start leaves the column register after the stage latency
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(ReconPkg::FtLatency) done);

endmodule

`default_nettype wire

/* src/QuantizeBlock.sv */
// Quantizer tables must stay stable from start until done; levels clamp at 2047 and Rout wraps to 16 bits
`timescale 1ns/100ps
`default_nettype none

module QuantizeBlock (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  start,
    input  wire  [ReconPkg::CoeffW*ReconPkg::NumCoeffs-1:0]      in,
    input  wire  [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]          q,
    input  wire  [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]          iq,
    input  wire  [ReconPkg::BiasW*ReconPkg::NumCoeffs-1:0]       bias,
    input  wire  [ReconPkg::BiasW*ReconPkg::NumCoeffs-1:0]       zthresh,
    input  wire  [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]          sharpen,
    output logic [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0]      Rout,
    output logic [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0]      out,
    output logic                                                 nz,
    output logic                                                 done
);

    logic [ReconPkg::NumCoeffs-1:0] signNext, signReg;
    logic [ReconPkg::NumCoeffs-1:0] passNext, passReg;
    logic [ReconPkg::AccW-1:0]      accNext [ReconPkg::NumCoeffs];
    logic [ReconPkg::AccW-1:0]      accReg  [ReconPkg::NumCoeffs];
    logic [ReconPkg::LevelW-1:0]    lvlNext [ReconPkg::NumCoeffs];
    logic [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0] routNext, outNext;
    logic anyNz;
    logic startQ;

    // --------------------------------------------------
    // Sharpen, threshold and multiply
    // --------------------------------------------------
    always_comb begin
        int     cv;
        longint mag;
        longint acc;
        for (int k = 0; k < ReconPkg::NumCoeffs; k++) begin
            cv  = int'($signed(in[k*ReconPkg::CoeffW +: ReconPkg::CoeffW]));
            mag = longint'(cv < 0 ? -cv : cv)
                + longint'(sharpen[k*ReconPkg::QW +: ReconPkg::QW]);
            acc = mag * longint'(iq[k*ReconPkg::QW +: ReconPkg::QW])
                + longint'(bias[k*ReconPkg::BiasW +: ReconPkg::BiasW]);
            signNext[k] = cv < 0;
            passNext[k] = mag > longint'(zthresh[k*ReconPkg::BiasW +: ReconPkg::BiasW]);
            accNext[k]  = acc[ReconPkg::AccW-1:0];
        end
    end

    // --------------------------------------------------
    // Shift, clamp, sign and dequantize
    // --------------------------------------------------
    always_comb begin
        longint lvl;
        longint rq;
        anyNz = 1'b0;
        for (int k = 0; k < ReconPkg::NumCoeffs; k++) begin
            lvl = longint'(accReg[k] >> ReconPkg::QFix);
            if (!passReg[k]) begin
                lvl = 0;
            end else if (lvl > ReconPkg::MaxLevel) begin
                lvl = ReconPkg::MaxLevel;
            end
            if (signReg[k]) begin
                lvl = -lvl;
            end
            rq         = lvl * longint'(q[k*ReconPkg::QW +: ReconPkg::QW]);
            lvlNext[k] = lvl[ReconPkg::LevelW-1:0];
            routNext[k*ReconPkg::LevelW +: ReconPkg::LevelW] = rq[ReconPkg::LevelW-1:0];
            anyNz = anyNz | (lvl != 0);
        end
        // Output levels in scan order
        for (int n = 0; n < ReconPkg::NumCoeffs; n++) begin
            outNext[n*ReconPkg::LevelW +: ReconPkg::LevelW] = lvlNext[ReconPkg::Zigzag[n]];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            signReg <= '0;
            passReg <= '0;
            accReg  <= '{default: '0};
            startQ  <= 1'b0;
            Rout    <= '0;
            out     <= '0;
            nz      <= 1'b0;
            done    <= 1'b0;
        end else begin
            signReg <= signNext;
            passReg <= passNext;
            accReg  <= accNext;
            startQ  <= start;
            Rout    <= routNext;
            out     <= outNext;
            nz      <= startQ & anyNz;
            done    <= startQ;
        end
    end

    // Levels handed on never exceed the clamp
    for (genvar n = 0; n < ReconPkg::NumCoeffs; n++) begin : gLevelChk
        assert property (@(posedge clk) disable iff (!rst_n)
            done |-> ($signed(out[n*ReconPkg::LevelW +: ReconPkg::LevelW]) <= ReconPkg::MaxLevel
                   && $signed(out[n*ReconPkg::LevelW +: ReconPkg::LevelW]) >= -ReconPkg::MaxLevel));
    end

    // nz only ever marks a block leaving this stage
    assert property (@(posedge clk) disable iff (!rst_n) nz |-> done);

endmodule

`default_nettype wire

/* src/ITransform.sv */
// Inverse 4x4 transform plus prediction add; refPix must be held until done and out is valid only with done
`timescale 1ns/100ps
`default_nettype none

module ITransform (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  start,
    input  wire  [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0]      src,
    input  wire  [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]        refPix,
    output logic [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]        out,
    output logic                                                 done
);

    int   vertNext [ReconPkg::NumCoeffs];
    int   vertReg  [ReconPkg::NumCoeffs];
    int   horzNext [ReconPkg::NumCoeffs];
    int   horzReg  [ReconPkg::NumCoeffs];
    logic [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0] pixNext;
    logic [1:0] startQ;

    // x * (1 + 20091/65536)
    function automatic int mul1(input int x);
        return ((x * ReconPkg::ItMulA) >>> 16) + x;
    endfunction

    // x * 35468/65536
    function automatic int mul2(input int x);
        return (x * ReconPkg::ItMulB) >>> 16;
    endfunction

    // --------------------------------------------------
    // Vertical pass, result stored column by column
    // --------------------------------------------------
    always_comb begin
        int s [ReconPkg::NumCoeffs];
        int a, b, c, d;
        for (int k = 0; k < ReconPkg::NumCoeffs; k++) begin
            s[k] = int'($signed(src[k*ReconPkg::LevelW +: ReconPkg::LevelW]));
        end
        for (int i = 0; i < ReconPkg::BlockSize; i++) begin
            a = s[i] + s[8+i];
            b = s[i] - s[8+i];
            c = mul2(s[4+i]) - mul1(s[12+i]);
            d = mul1(s[4+i]) + mul2(s[12+i]);
            vertNext[i*4+0] = a + d;
            vertNext[i*4+1] = b + c;
            vertNext[i*4+2] = b - c;
            vertNext[i*4+3] = a - d;
        end
    end

    // --------------------------------------------------
    // Horizontal pass with rounding
    // --------------------------------------------------
    always_comb begin
        int dc, a, b, c, d;
        for (int i = 0; i < ReconPkg::BlockSize; i++) begin
            dc = vertReg[i] + 4;
            a  = dc + vertReg[8+i];
            b  = dc - vertReg[8+i];
            c  = mul2(vertReg[4+i]) - mul1(vertReg[12+i]);
            d  = mul1(vertReg[4+i]) + mul2(vertReg[12+i]);
            horzNext[i*4+0] = (a + d) >>> 3;
            horzNext[i*4+1] = (b + c) >>> 3;
            horzNext[i*4+2] = (b - c) >>> 3;
            horzNext[i*4+3] = (a - d) >>> 3;
        end
    end

    // Prediction add and clip to the pixel range
    always_comb begin
        int v;
        for (int k = 0; k < ReconPkg::NumCoeffs; k++) begin
            v = int'(refPix[k*ReconPkg::PixW +: ReconPkg::PixW]) + horzReg[k];
            if (v < 0) begin
                v = 0;
            end else if (v > (1 << ReconPkg::PixW) - 1) begin
                v = (1 << ReconPkg::PixW) - 1;
            end
            pixNext[k*ReconPkg::PixW +: ReconPkg::PixW] = v[ReconPkg::PixW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vertReg <= '{default: 0};
            horzReg <= '{default: 0};
            out     <= '0;
            startQ  <= 2'b00;
            done    <= 1'b0;
        end else begin
            vertReg <= vertNext;
            horzReg <= horzNext;
            out     <= pixNext;
            startQ  <= {startQ[0], start};
            done    <= startQ[1];
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(ReconPkg::ItLatency) done);

endmodule

`default_nettype wire

/* src/Reconstruct4.sv */
// Done follows start by 7 cycles; YPred is held per block and tables stay stable while in flight
`timescale 1ns/100ps
`default_nettype none

module Reconstruct4 (
    input  wire                                                  clk,
    input  wire                                                  rst_n,
    input  wire                                                  start,
    input  wire [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]         YPred,
    input  wire [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]         Ysrc,
    input  wire [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]           q,
    input  wire [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]           iq,
    input  wire [ReconPkg::BiasW*ReconPkg::NumCoeffs-1:0]        bias,
    input  wire [ReconPkg::BiasW*ReconPkg::NumCoeffs-1:0]        zthresh,
    input  wire [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]           sharpen,
    output wire [ReconPkg::PixW*ReconPkg::NumCoeffs-1:0]         Yout,
    output wire [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0]       YLevels,
    output wire                                                  nz,
    output wire                                                  done
);

    logic [ReconPkg::QW*ReconPkg::NumCoeffs-1:0]    qReg, iqReg, sharpenReg;
    logic [ReconPkg::BiasW*ReconPkg::NumCoeffs-1:0] biasReg, zthreshReg;

    wire  [ReconPkg::CoeffW*ReconPkg::NumCoeffs-1:0] ftCoeffs;
    wire  [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0] qbRout;
    wire  [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0] qbLevels;
    wire  qbNz;
    wire  ftDone;
    wire  qbDone;

    // Levels and nz wait for the inverse transform so they leave with done
    logic [ReconPkg::LevelW*ReconPkg::NumCoeffs-1:0] levelPipe [ReconPkg::ItLatency];
    logic [ReconPkg::ItLatency-1:0]                  nzPipe;

    // --------------------------------------------------
    // Quantizer tables held in one register stage
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            qReg       <= '0;
            iqReg      <= '0;
            biasReg    <= '0;
            zthreshReg <= '0;
            sharpenReg <= '0;
        end else begin
            qReg       <= q;
            iqReg      <= iq;
            biasReg    <= bias;
            zthreshReg <= zthresh;
            sharpenReg <= sharpen;
        end
    end

    FTransform uFTransform (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .src     (Ysrc),
        .refPix  (YPred),
        .out     (ftCoeffs),
        .done    (ftDone)
    );

    QuantizeBlock uQuantizeBlock (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (ftDone),
        .in      (ftCoeffs),
        .q       (qReg),
        .iq      (iqReg),
        .bias    (biasReg),
        .zthresh (zthreshReg),
        .sharpen (sharpenReg),
        .Rout    (qbRout),
        .out     (qbLevels),
        .nz      (qbNz),
        .done    (qbDone)
    );

    ITransform uITransform (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (qbDone),
        .src     (qbRout),
        .refPix  (YPred),
        .out     (Yout),
        .done    (done)
    );

    // --------------------------------------------------
    // Level and nz delay matching the inverse transform
    // --------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            levelPipe <= '{default: '0};
            nzPipe    <= '0;
        end else begin
            levelPipe[0] <= qbLevels;
            for (int i = 1; i < ReconPkg::ItLatency; i++) begin
                levelPipe[i] <= levelPipe[i-1];
            end
            nzPipe <= {nzPipe[ReconPkg::ItLatency-2:0], qbNz};
        end
    end

    assign YLevels = levelPipe[ReconPkg::ItLatency-1];
    assign nz      = nzPipe[ReconPkg::ItLatency-1];

    // End-to-end latency across all three stages
    assert property (@(posedge clk) disable iff (!rst_n)
        start |-> ##(ReconPkg::FtLatency + ReconPkg::QbLatency + ReconPkg::ItLatency) done);

endmodule

`default_nettype wire

/* bench/tbReconstruct4.sv */
// Run from the project root so bench/reconVectors.txt resolves; blocks sharing YPred and tables go back to back
`timescale 1ns/100ps
`default_nettype none

module tbReconstruct4;

    localparam int PixBus    = ReconPkg::PixW * ReconPkg::NumCoeffs;
    localparam int QBus      = ReconPkg::QW * ReconPkg::NumCoeffs;
    localparam int BiasBus   = ReconPkg::BiasW * ReconPkg::NumCoeffs;
    localparam int LevelBus  = ReconPkg::LevelW * ReconPkg::NumCoeffs;
    localparam int Latency   = ReconPkg::FtLatency + ReconPkg::QbLatency + ReconPkg::ItLatency;
    localparam int Timeout   = 20;
    localparam int MaxBlocks = 16;

    // Quantizer with step 4 and no bias, used by the generated blocks
    localparam logic [QBus-1:0] BaseQ  = {ReconPkg::NumCoeffs{16'h0004}};
    localparam logic [QBus-1:0] BaseIq = {ReconPkg::NumCoeffs{16'h8000}};

    logic                clk;
    logic                rst_n;
    logic                start;
    logic [PixBus-1:0]   YPred;
    logic [PixBus-1:0]   Ysrc;
    logic [QBus-1:0]     q;
    logic [QBus-1:0]     iq;
    logic [BiasBus-1:0]  bias;
    logic [BiasBus-1:0]  zthresh;
    logic [QBus-1:0]     sharpen;
    wire  [PixBus-1:0]   Yout;
    wire  [LevelBus-1:0] YLevels;
    wire                 nz;
    wire                 done;

    // Vector table
    logic [8*32-1:0]     vName    [MaxBlocks];
    logic [PixBus-1:0]   vSrc     [MaxBlocks];
    logic [PixBus-1:0]   vPred    [MaxBlocks];
    logic [QBus-1:0]     vQ       [MaxBlocks];
    logic [QBus-1:0]     vIq      [MaxBlocks];
    logic [BiasBus-1:0]  vBias    [MaxBlocks];
    logic [BiasBus-1:0]  vZthresh [MaxBlocks];
    logic [QBus-1:0]     vSharpen [MaxBlocks];
    logic [LevelBus-1:0] vLevels  [MaxBlocks];
    logic                vNz      [MaxBlocks];
    logic [PixBus-1:0]   vYout    [MaxBlocks];
    int                  issueAt  [MaxBlocks];
    int                  numBlocks = 0;
    int                  cycle = 0;

    Reconstruct4 i_Reconstruct4 (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .YPred   (YPred),
        .Ysrc    (Ysrc),
        .q       (q),
        .iq      (iq),
        .bias    (bias),
        .zthresh (zthresh),
        .sharpen (sharpen),
        .Yout    (Yout),
        .YLevels (YLevels),
        .nz      (nz),
        .done    (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) cycle <= cycle + 1;

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic loadVectors();
        int fd;
        int code;
        string line;
        logic [8*32-1:0] nm;
        logic [PixBus-1:0] s, p, y;
        logic [QBus-1:0] tq, tiq, tsh;
        logic [BiasBus-1:0] tb, tz;
        logic [LevelBus-1:0] lv;
        logic tnz;
        fd = $fopen("bench/reconVectors.txt", "r");
        if (fd == 0) begin
            failRun("could not open the vector file bench/reconVectors.txt");
        end
        while (!$feof(fd)) begin
            code = $fgets(line, fd);
            // Skip comments and blank lines
            if (code > 0 && line.len() > 1 && line.getc(0) != 8'h23) begin
                code = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h",
                               nm, s, p, tq, tiq, tb, tz, tsh, lv, tnz, y);
                if (code != 11 || numBlocks >= MaxBlocks) begin
                    failRun("vector file has a malformed line or too many blocks");
                end
                vName[numBlocks]    = nm;
                vSrc[numBlocks]     = s;
                vPred[numBlocks]    = p;
                vQ[numBlocks]       = tq;
                vIq[numBlocks]      = tiq;
                vBias[numBlocks]    = tb;
                vZthresh[numBlocks] = tz;
                vSharpen[numBlocks] = tsh;
                vLevels[numBlocks]  = lv;
                vNz[numBlocks]      = tnz;
                vYout[numBlocks]    = y;
                numBlocks++;
            end
        end
        $fclose(fd);
    endtask

    function automatic logic [PixBus-1:0] randomPixels();
        logic [PixBus-1:0] r;
        for (int k = 0; k < ReconPkg::NumCoeffs; k++) begin
            r[k*ReconPkg::PixW +: ReconPkg::PixW] = 8'($urandom);
        end
        return r;
    endfunction

    // Prediction and tables, then let the table register settle
    task automatic applySetup(input logic [PixBus-1:0] pred, input logic [QBus-1:0] tq,
                              input logic [QBus-1:0] tiq, input logic [BiasBus-1:0] tb,
                              input logic [BiasBus-1:0] tz, input logic [QBus-1:0] tsh);
        @(posedge clk);
        YPred   <= pred;
        q       <= tq;
        iq      <= tiq;
        bias    <= tb;
        zthresh <= tz;
        sharpen <= tsh;
        repeat (3) @(posedge clk);
    endtask

    task automatic issueBlock(input logic [PixBus-1:0] src, output int at);
        @(posedge clk);
        start <= 1'b1;
        Ysrc  <= src;
        @(negedge clk);
        at = cycle;
    endtask

    task automatic endIssue();
        @(posedge clk);
        start <= 1'b0;
    endtask

    task automatic waitDone();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < Timeout);
        if (!done) begin
            failRun("timeout: done did not arrive within 20 cycles");
        end
    endtask

    task automatic checkResult(input logic [8*32-1:0] name, input logic [LevelBus-1:0] expLv,
                               input logic expNz, input logic [PixBus-1:0] expY,
                               input int expCycle);
        assert (cycle == expCycle) else
            failRun($sformatf("mismatch %0s done cycle expected %0d actual %0d",
                              name, expCycle, cycle));
        assert (YLevels == expLv) else
            failRun($sformatf("mismatch %0s YLevels expected %h actual %h", name, expLv, YLevels));
        assert (nz == expNz) else
            failRun($sformatf("mismatch %0s nz expected %0d actual %0d", name, expNz, nz));
        assert (Yout == expY) else
            failRun($sformatf("mismatch %0s Yout expected %h actual %h", name, expY, Yout));
    endtask

    function automatic bit sameSetup(input int a, input int b);
        return vPred[a] == vPred[b] && vQ[a] == vQ[b] && vIq[a] == vIq[b]
            && vBias[a] == vBias[b] && vZthresh[a] == vZthresh[b]
            && vSharpen[a] == vSharpen[b];
    endfunction

    task automatic runGenerated(input logic [8*32-1:0] name, input logic [PixBus-1:0] src,
                                input logic [PixBus-1:0] pred, input logic [BiasBus-1:0] tz);
        int at;
        applySetup(pred, BaseQ, BaseIq, '0, tz, '0);
        issueBlock(src, at);
        endIssue();
        waitDone();
        // No level survives, so the reconstruction is the prediction itself
        checkResult(name, '0, 1'b0, pred, at + Latency);
    endtask

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        logic [PixBus-1:0] pix;
        int at;
        int last;
        clk     = 1'b0;
        rst_n   = 1'b0;
        start   = 1'b0;
        YPred   = '0;
        Ysrc    = '0;
        q       = '0;
        iq      = '0;
        bias    = '0;
        zthresh = '0;
        sharpen = '0;
        void'($urandom(23));
        loadVectors();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;

        // Idle pipeline stays quiet
        repeat (5) begin
            @(negedge clk);
            assert (!done && !nz) else
                failRun("done or nz went high with no block in flight");
        end

        pix = randomPixels();
        runGenerated("zeroResidual", pix, pix, '0);
        runGenerated("zeroThresh", randomPixels(), randomPixels(), '1);

        // Each file block on its own
        for (int j = 0; j < numBlocks; j++) begin
            applySetup(vPred[j], vQ[j], vIq[j], vBias[j], vZthresh[j], vSharpen[j]);
            issueBlock(vSrc[j], at);
            endIssue();
            waitDone();
            checkResult(vName[j], vLevels[j], vNz[j], vYout[j], at + Latency);
        end

        // Runs of matching setup issued on consecutive cycles
        for (int j = 0; j < numBlocks; j = last + 1) begin
            last = j;
            while (last + 1 < numBlocks && sameSetup(j, last + 1)) begin
                last++;
            end
            applySetup(vPred[j], vQ[j], vIq[j], vBias[j], vZthresh[j], vSharpen[j]);
            for (int b = j; b <= last; b++) begin
                issueBlock(vSrc[b], issueAt[b]);
            end
            endIssue();
            for (int b = j; b <= last; b++) begin
                waitDone();
                checkResult(vName[b], vLevels[b], vNz[b], vYout[b], issueAt[b] + Latency);
            end
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/reconVectors.txt */
# name Ysrc YPred q iq bias zthresh sharpen expYLevels(zigzag) expNz expYout
# buses in hex, entry 0 in the lowest digits
dcPos 78787878787878787878787878787878 64646464646464646464646464646464 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 0 28 1 78787878787878787878787878787878
dcSmall 65656565656565656565656565656565 64646464646464646464646464646464 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 0 2 1 65656565656565656565656565656565
dcNeg 50505050505050505050505050505050 64646464646464646464646464646464 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 0 ffd8 1 50505050505050505050505050505050
sharpenZz 67676767676767676767676767676767 64646464646464646464646464646464 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 00080000000000000004 000200000007 1 66666666676767676868686869696969
clampHigh ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 2000 7ff 1 ffffffffffffffffffffffffffffffff
clampLow 00000000000000000000000000000000 c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8 0004000400040004000400040004000400040004000400040004000400040004 8000800080008000800080008000800080008000800080008000800080008000 0 0 2000 f801 1 00000000000000000000000000000000

/* files.f */
src/ReconPkg.sv
src/FTransform.sv
src/QuantizeBlock.sv
src/ITransform.sv
src/Reconstruct4.sv
bench/tbReconstruct4.sv

/* Makefile */
VERILATOR ?= verilator
TOP       := tbReconstruct4
FILELIST  := files.f
BUILD_DIR := obj_dir
VFLAGS    := --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir $(BUILD_DIR)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
